// ==== src/eye_pkg.sv ====
/*
 * Eye tracker shared definitions
 * Pixel, coordinate and sum widths, camera and Wishbone bus structs,
 * the gravity result bundle and the host register map.
 */

package eye_pkg;

    // --------------------
    // Widths with a meaning
    // --------------------
    typedef logic [7:0]  pixel_t;
    typedef logic [9:0]  coord_t;
    typedef logic [19:0] sum_s_t;
    typedef logic [27:0] sum_xy_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_addr_t;

    // --------------------
    // Bus bundles
    // --------------------

    // One Camera Link tap, all active high
    typedef struct packed {
        logic   fval;
        logic   lval;
        logic   dval;
        pixel_t data;
    } cam_bus_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat_r;
    } wb_rsp_t;

    // Frame sums handed from the accumulator to dividers and registers
    typedef struct packed {
        sum_s_t  sum_s;
        sum_xy_t sum_sx;
        sum_xy_t sum_sy;
    } gravity_t;

    // --------------------
    // Register map
    // --------------------
    localparam wb_data_t EYE_ID = 32'h4559_4531;

    localparam wb_addr_t REG_ID     = 4'd0;
    localparam wb_addr_t REG_CTRL   = 4'd1;
    localparam wb_addr_t REG_STATUS = 4'd2;
    localparam wb_addr_t REG_SUM_S  = 4'd3;
    localparam wb_addr_t REG_SUM_SX = 4'd4;
    localparam wb_addr_t REG_SUM_SY = 4'd5;
    localparam wb_addr_t REG_CENTER = 4'd6;

endpackage

// ==== src/cam_input.sv ====
/*
 * Camera input stage
 * Registers one Camera Link tap, tracks pixel column and row and
 * produces the pixel strobe and a frame-end pulse.
 */

`timescale 1ns/10ps

module cam_input (
    input  logic              clk,
    input  logic              rst,
    input  eye_pkg::cam_bus_t cam,
    output logic              pix_valid,
    output eye_pkg::coord_t   pix_x,
    output eye_pkg::coord_t   pix_y,
    output eye_pkg::pixel_t   pix_data,
    output logic              frame_end
);

    logic              fval_q;
    logic              lval_q;
    eye_pkg::coord_t   col_cnt;
    eye_pkg::coord_t   row_cnt;
    eye_pkg::coord_t   col_base;
    logic              pix_take;
    logic              lval_rise;
    logic              lval_fall;
    logic              fval_rise;
    logic              fval_fall;

    // Edges against the previous sample of the bus
    assign lval_rise = cam.lval & ~lval_q;
    assign lval_fall = ~cam.lval & lval_q;
    assign fval_rise = cam.fval & ~fval_q;
    assign fval_fall = ~cam.fval & fval_q;
    assign pix_take  = cam.fval & cam.lval & cam.dval;

    // Column restarts at each new line
    assign col_base = lval_rise ? '0 : col_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            fval_q    <= 1'b0;
            lval_q    <= 1'b0;
            col_cnt   <= '0;
            row_cnt   <= '0;
            pix_valid <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            fval_q    <= cam.fval;
            lval_q    <= cam.lval;
            col_cnt   <= col_base + eye_pkg::coord_t'(pix_take);
            pix_valid <= pix_take;
            frame_end <= fval_fall;
            if (fval_rise) begin
                row_cnt <= '0;
            end else if (lval_fall) begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // Pixel payload travels alongside the strobe
    always_ff @(posedge clk) begin
        pix_data <= cam.data;
        pix_x    <= col_base;
        pix_y    <= fval_rise ? '0 : row_cnt;
    end

endmodule

// ==== src/gravity_accum.sv ====
/*
 * Centre of gravity accumulator
 * Counts pixels at or above the threshold and sums their column and row
 * over a frame. The totals are latched at frame end.
 */

`timescale 1ns/10ps

module gravity_accum (
    input  logic              clk,
    input  logic              rst,
    input  logic              pix_valid,
    input  eye_pkg::coord_t   pix_x,
    input  eye_pkg::coord_t   pix_y,
    input  eye_pkg::pixel_t   pix_data,
    input  logic              frame_end,
    input  eye_pkg::pixel_t   threshold,
    input  logic              enable,
    output eye_pkg::gravity_t gravity,
    output logic              calc_start
);

    eye_pkg::sum_s_t  acc_s;
    eye_pkg::sum_xy_t acc_sx;
    eye_pkg::sum_xy_t acc_sy;
    logic             hit;

    // Target pixel test
    assign hit = pix_valid & (pix_data >= threshold);

    // --------------------
    // Running sums
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_s      <= '0;
            acc_sx     <= '0;
            acc_sy     <= '0;
            calc_start <= 1'b0;
        end else begin
            calc_start <= frame_end & enable;
            // Disabled frames are dropped, sums restart for the next one
            if (frame_end || !enable) begin
                acc_s  <= '0;
                acc_sx <= '0;
                acc_sy <= '0;
            end else if (hit) begin
                acc_s  <= acc_s + 1'b1;
                acc_sx <= acc_sx + eye_pkg::sum_xy_t'(pix_x);
                acc_sy <= acc_sy + eye_pkg::sum_xy_t'(pix_y);
            end
        end
    end

    // --------------------
    // Frame result
    // --------------------
    always_ff @(posedge clk) begin
        if (frame_end && enable) begin
            gravity.sum_s  <= acc_s;
            gravity.sum_sx <= acc_sx;
            gravity.sum_sy <= acc_sy;
        end
    end

endmodule

// ==== src/gravity_divider.sv ====
/*
 * Restoring divider
 * One quotient bit per cycle, NUM_WIDTH steps after start. Gives the
 * centre coordinate from a coordinate sum and the pixel count.
 */

`timescale 1ns/10ps

module gravity_divider #(
    parameter int NUM_WIDTH = 28
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  eye_pkg::sum_xy_t dividend,
    input  eye_pkg::sum_s_t  divisor,
    output eye_pkg::coord_t  quotient,
    output logic             done
);

    localparam int DEN_WIDTH = $bits(eye_pkg::sum_s_t);
    localparam int Q_WIDTH   = $bits(eye_pkg::coord_t);
    localparam int CNT_WIDTH = $clog2(NUM_WIDTH + 1);

    logic [NUM_WIDTH-1:0] num_q;
    logic [NUM_WIDTH-1:0] num_next;
    logic [DEN_WIDTH-1:0] den_q;
    logic [DEN_WIDTH-1:0] rem_q;
    logic [DEN_WIDTH:0]   rem_shift;
    logic [DEN_WIDTH:0]   rem_diff;
    logic [CNT_WIDTH-1:0] cnt_q;
    logic                 busy_q;
    logic                 fits;
    logic                 last_step;

    // One restoring step
    always_comb begin
        rem_shift = {rem_q, num_q[NUM_WIDTH-1]};
        rem_diff  = rem_shift - {1'b0, den_q};
        fits      = (rem_shift >= {1'b0, den_q});
        // Dividend bits leave at the top, quotient bits enter at the bottom
        num_next  = (num_q << 1) | NUM_WIDTH'(fits);
    end

    assign last_step = busy_q && (cnt_q == CNT_WIDTH'(1));

    // --------------------
    // Step control
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            done   <= 1'b0;
        end else begin
            done <= last_step & ~start;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_WIDTH'(NUM_WIDTH);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (last_step) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // --------------------
    // Datapath
    // --------------------
    always_ff @(posedge clk) begin
        if (start) begin
            num_q <= NUM_WIDTH'(dividend);
            den_q <= divisor;
            rem_q <= '0;
        end else if (busy_q) begin
            num_q <= num_next;
            rem_q <= fits ? rem_diff[DEN_WIDTH-1:0] : rem_shift[DEN_WIDTH-1:0];
            // Zero count means no target, centre reported as zero
            if (last_step) begin
                quotient <= (den_q == '0) ? '0 : num_next[Q_WIDTH-1:0];
            end
        end
    end

endmodule

// ==== src/eye_regs.sv ====
/*
 * Host register bank
 * Wishbone classic slave with the control, status, frame count
 * and result registers of the eye tracker.
 */

`timescale 1ns/10ps

module eye_regs #(
    parameter eye_pkg::pixel_t THRESHOLD_INIT = 8'h80
) (
    input  logic              clk,
    input  logic              rst,
    input  eye_pkg::wb_req_t  wb_req,
    output eye_pkg::wb_rsp_t  wb_rsp,
    input  eye_pkg::gravity_t gravity,
    input  logic              calc_start,
    input  eye_pkg::coord_t   center_x,
    input  eye_pkg::coord_t   center_y,
    input  logic              div_done,
    output eye_pkg::pixel_t   threshold,
    output logic              enable
);

    logic              ack_q;
    eye_pkg::wb_data_t dat_r_q;
    eye_pkg::wb_data_t rd_data;
    logic              access;
    logic              wr_en;

    logic              result_valid;
    logic              no_target;
    logic [15:0]       frame_cnt;
    eye_pkg::sum_s_t   sum_s_q;
    eye_pkg::sum_xy_t  sum_sx_q;
    eye_pkg::sum_xy_t  sum_sy_q;
    eye_pkg::coord_t   cx_q;
    eye_pkg::coord_t   cy_q;

    // New request seen while no ack is out
    assign access = wb_req.cyc & wb_req.stb & ~ack_q;
    assign wr_en  = access & wb_req.we;

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            eye_pkg::REG_ID:     rd_data = eye_pkg::EYE_ID;
            eye_pkg::REG_CTRL:   rd_data = {23'd0, enable, threshold};
            eye_pkg::REG_STATUS: rd_data = {frame_cnt, 14'd0, no_target, result_valid};
            eye_pkg::REG_SUM_S:  rd_data = eye_pkg::wb_data_t'(sum_s_q);
            eye_pkg::REG_SUM_SX: rd_data = eye_pkg::wb_data_t'(sum_sx_q);
            eye_pkg::REG_SUM_SY: rd_data = eye_pkg::wb_data_t'(sum_sy_q);
            eye_pkg::REG_CENTER: rd_data = {6'd0, cy_q, 6'd0, cx_q};
            default:             rd_data = '0;
        endcase
    end

    // --------------------
    // Bus handshake
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_r_q <= rd_data;
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;

    // --------------------
    // Control and status
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            threshold    <= THRESHOLD_INIT;
            enable       <= 1'b0;
            result_valid <= 1'b0;
            no_target    <= 1'b0;
            frame_cnt    <= '0;
        end else begin
            if (wr_en && wb_req.adr == eye_pkg::REG_CTRL) begin
                threshold <= wb_req.dat_w[7:0];
                enable    <= wb_req.dat_w[8];
            end
            if (calc_start) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            // A finished division wins over a host clear
            if (div_done) begin
                result_valid <= 1'b1;
                no_target    <= (sum_s_q == '0);
            end else if (calc_start) begin
                result_valid <= 1'b0;
            end else if (wr_en && wb_req.adr == eye_pkg::REG_STATUS && wb_req.dat_w[0]) begin
                result_valid <= 1'b0;
            end
        end
    end

    // Results, held until the next frame
    always_ff @(posedge clk) begin
        if (rst) begin
            sum_s_q  <= '0;
            sum_sx_q <= '0;
            sum_sy_q <= '0;
            cx_q     <= '0;
            cy_q     <= '0;
        end else begin
            if (calc_start) begin
                sum_s_q  <= gravity.sum_s;
                sum_sx_q <= gravity.sum_sx;
                sum_sy_q <= gravity.sum_sy;
            end
            if (div_done) begin
                cx_q <= center_x;
                cy_q <= center_y;
            end
        end
    end

endmodule

// ==== src/eye_tracker_top.sv ====
/*
 * Eye tracker measurement core
 * Camera input, frame accumulator, x and y dividers and the
 * Wishbone register bank on a single clock.
 */

`timescale 1ns/10ps

module eye_tracker_top #(
    parameter eye_pkg::pixel_t THRESHOLD_INIT = 8'h80
) (
    input  logic              clk,
    input  logic              rst,
    input  eye_pkg::cam_bus_t cam,
    input  eye_pkg::wb_req_t  wb_req,
    output eye_pkg::wb_rsp_t  wb_rsp
);

    localparam int NUM_WIDTH = $bits(eye_pkg::sum_xy_t);

    logic              pix_valid;
    eye_pkg::coord_t   pix_x;
    eye_pkg::coord_t   pix_y;
    eye_pkg::pixel_t   pix_data;
    logic              frame_end;
    eye_pkg::pixel_t   threshold;
    logic              enable;
    eye_pkg::gravity_t gravity;
    logic              calc_start;
    eye_pkg::coord_t   center_x;
    eye_pkg::coord_t   center_y;
    logic              done_x;
    logic              done_y;

    // --------------------
    // Pixel path
    // --------------------
    cam_input u_cam_input (
        .clk       (clk),
        .rst       (rst),
        .cam       (cam),
        .pix_valid (pix_valid),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .pix_data  (pix_data),
        .frame_end (frame_end)
    );

    gravity_accum u_gravity_accum (
        .clk        (clk),
        .rst        (rst),
        .pix_valid  (pix_valid),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .pix_data   (pix_data),
        .frame_end  (frame_end),
        .threshold  (threshold),
        .enable     (enable),
        .gravity    (gravity),
        .calc_start (calc_start)
    );

    // Both dividers start together and finish together
    gravity_divider #(.NUM_WIDTH(NUM_WIDTH)) u_div_x (
        .clk      (clk),
        .rst      (rst),
        .start    (calc_start),
        .dividend (gravity.sum_sx),
        .divisor  (gravity.sum_s),
        .quotient (center_x),
        .done     (done_x)
    );

    gravity_divider #(.NUM_WIDTH(NUM_WIDTH)) u_div_y (
        .clk      (clk),
        .rst      (rst),
        .start    (calc_start),
        .dividend (gravity.sum_sy),
        .divisor  (gravity.sum_s),
        .quotient (center_y),
        .done     (done_y)
    );

    // --------------------
    // Host side
    // --------------------
    eye_regs #(.THRESHOLD_INIT(THRESHOLD_INIT)) u_eye_regs (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .gravity    (gravity),
        .calc_start (calc_start),
        .center_x   (center_x),
        .center_y   (center_y),
        .div_done   (done_x & done_y),
        .threshold  (threshold),
        .enable     (enable)
    );

endmodule

// ==== tests/eye_tracker_props.sv ====
/*
 * Wishbone port properties
 * Bound to the eye tracker top level, checks the ack handshake.
 */

`timescale 1ns/10ps

module eye_tracker_props (
    input logic             clk,
    input logic             rst,
    input eye_pkg::wb_req_t wb_req,
    input eye_pkg::wb_rsp_t wb_rsp
);

    // No ack right out of reset
    ack_after_reset: assert property (@(posedge clk) $fell(rst) |=> !wb_rsp.ack)
        else $error("ack high in the first cycle after reset");

    // Ack answers a request seen on the edge before
    ack_needs_request: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack without a preceding cyc and stb");

    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("ack held for more than one cycle");

endmodule

bind eye_tracker_top eye_tracker_props u_props (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
);

// ==== tests/tb_eye_tracker.sv ====
/*
 * Eye tracker testbench
 * Random camera frames, Wishbone register access and a software model
 * of the frame sums and the centre of gravity.
 */

`timescale 1ns/10ps

module tb_eye_tracker;

    localparam logic [31:0] LFSR_SEED    = 32'ha1fe662b;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
    localparam int          COLS         = 32;
    localparam int          ROWS         = 16;
    localparam int          ACK_TIMEOUT  = 20;
    localparam int          RESULT_POLLS = 100;

    logic              clk;
    logic              rst;
    eye_pkg::cam_bus_t cam;
    eye_pkg::wb_req_t  wb_req;
    eye_pkg::wb_rsp_t  wb_rsp;

    logic [31:0] lfsr;
    logic [7:0]  frame_pix [ROWS][COLS];
    logic [31:0] exp_s;
    logic [31:0] exp_sx;
    logic [31:0] exp_sy;
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    string       test_name;

    eye_tracker_top #(.THRESHOLD_INIT(8'h80)) uut (
        .clk    (clk),
        .rst    (rst),
        .cam    (cam),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------
    // Random source
    // --------------------

    // Galois step, returns the bit shifted out
    function automatic logic take_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ LFSR_TAPS;
        end
        return b;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            v = {v[6:0], take_bit()};
        end
        return v;
    endfunction

    // --------------------
    // Checking helpers
    // --------------------
    task automatic check_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    // --------------------
    // Wishbone master
    // --------------------
    task automatic wait_ack(output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            ok = wb_rsp.ack;
            n++;
        end
    endtask

    task automatic bus_write(input eye_pkg::wb_addr_t adr, input logic [31:0] data);
        logic ok;
        @(posedge clk);
        #1;
        wb_req = {1'b1, 1'b1, 1'b1, adr, data};
        wait_ack(ok);
        wb_req = '0;
        if (!ok) begin
            $display("no Wishbone ack for write to address %0d", adr);
            errors++;
        end
    endtask

    task automatic bus_read(input eye_pkg::wb_addr_t adr, output logic [31:0] data);
        logic ok;
        @(posedge clk);
        #1;
        wb_req = {1'b1, 1'b1, 1'b0, adr, 32'd0};
        wait_ack(ok);
        data   = wb_rsp.dat_r;
        wb_req = '0;
        if (!ok) begin
            $display("no Wishbone ack for read of address %0d", adr);
            errors++;
        end
    endtask

    // --------------------
    // Camera frames and model
    // --------------------
    task automatic drive_cam(input logic f, input logic l, input logic d, input logic [7:0] px);
        @(posedge clk);
        #1;
        cam = {f, l, d, px};
    endtask

    // Low-only frames keep every pixel under 8'h80
    task automatic send_frame(input logic low_only);
        logic [7:0] p;
        repeat (3) drive_cam(1'b0, 1'b0, 1'b0, 8'h00);
        repeat (2) drive_cam(1'b1, 1'b0, 1'b0, 8'h00);
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                p = random_byte();
                if (low_only) begin
                    p = p & 8'h7f;
                end
                frame_pix[r][c] = p;
                drive_cam(1'b1, 1'b1, 1'b1, p);
            end
            repeat (4) drive_cam(1'b1, 1'b0, 1'b0, 8'h00);
        end
        repeat (5) drive_cam(1'b0, 1'b0, 1'b0, 8'h00);
    endtask

    task automatic compute_model(input logic [7:0] thr);
        exp_s  = 0;
        exp_sx = 0;
        exp_sy = 0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                if (frame_pix[r][c] >= thr) begin
                    exp_s  = exp_s + 1;
                    exp_sx = exp_sx + c;
                    exp_sy = exp_sy + r;
                end
            end
        end
    endtask

    task automatic wait_result();
        logic [31:0] st;
        int          n;
        n     = 0;
        st    = '0;
        while (!st[0] && n < RESULT_POLLS) begin
            bus_read(eye_pkg::REG_STATUS, st);
            n++;
        end
        if (!st[0]) begin
            $display("result valid did not set after %0d status reads", n);
            errors++;
        end
    endtask

    task automatic check_sums();
        logic [31:0] rd;
        bus_read(eye_pkg::REG_SUM_S, rd);
        check_word("sum_s", exp_s, rd);
        bus_read(eye_pkg::REG_SUM_SX, rd);
        check_word("sum_sx", exp_sx, rd);
        bus_read(eye_pkg::REG_SUM_SY, rd);
        check_word("sum_sy", exp_sy, rd);
    endtask

    // Truncating division, zero when nothing was hit
    task automatic check_center();
        logic [31:0] rd;
        logic [31:0] cx;
        logic [31:0] cy;
        cx = (exp_s == 0) ? 32'd0 : exp_sx / exp_s;
        cy = (exp_s == 0) ? 32'd0 : exp_sy / exp_s;
        bus_read(eye_pkg::REG_CENTER, rd);
        check_word("centre", {6'd0, cy[9:0], 6'd0, cx[9:0]}, rd);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [31:0] rd;
        logic [31:0] cnt_before;
        lfsr   = LFSR_SEED;
        errors = 0;
        checks = 0;
        tests  = 0;
        rst    = 1'b1;
        cam    = '0;
        wb_req = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("id_ctrl");
        bus_read(eye_pkg::REG_ID, rd);
        check_word("id", eye_pkg::EYE_ID, rd);
        bus_read(eye_pkg::REG_CTRL, rd);
        check_word("ctrl after reset", 32'h0000_0080, rd);
        bus_write(eye_pkg::REG_CTRL, 32'h0000_01a5);
        bus_read(eye_pkg::REG_CTRL, rd);
        check_word("ctrl readback", 32'h0000_01a5, rd);
        end_test();

        begin_test("sums_thr80");
        bus_write(eye_pkg::REG_CTRL, 32'h0000_0180);
        send_frame(1'b0);
        compute_model(8'h80);
        wait_result();
        check_sums();
        bus_read(eye_pkg::REG_STATUS, rd);
        check_word("frame count", 32'd1, {16'd0, rd[31:16]});
        end_test();

        begin_test("centre");
        check_center();
        end_test();

        begin_test("sums_thrf0");
        bus_write(eye_pkg::REG_CTRL, 32'h0000_01f0);
        send_frame(1'b0);
        compute_model(8'hf0);
        wait_result();
        check_sums();
        check_center();
        bus_write(eye_pkg::REG_STATUS, 32'h0000_0001);
        bus_read(eye_pkg::REG_STATUS, rd);
        check_word("result valid after clear", 32'd0, {31'd0, rd[0]});
        end_test();

        begin_test("no_target");
        send_frame(1'b1);
        compute_model(8'hf0);
        wait_result();
        check_sums();
        check_center();
        bus_read(eye_pkg::REG_STATUS, rd);
        check_word("no target flag", 32'd1, {31'd0, rd[1]});
        end_test();

        // Sums from the previous frame must survive
        begin_test("disabled");
        // Enabled frame first so the held sums are not zero
        bus_write(eye_pkg::REG_CTRL, 32'h0000_0110);
        send_frame(1'b0);
        compute_model(8'h10);
        wait_result();
        bus_write(eye_pkg::REG_CTRL, 32'h0000_0010);
        bus_read(eye_pkg::REG_STATUS, rd);
        cnt_before = {16'd0, rd[31:16]};
        send_frame(1'b0);
        repeat (60) @(posedge clk);
        bus_read(eye_pkg::REG_STATUS, rd);
        check_word("frame count", cnt_before, {16'd0, rd[31:16]});
        check_sums();
        end_test();

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
src/eye_pkg.sv
src/cam_input.sv
src/gravity_accum.sv
src/gravity_divider.sv
src/eye_regs.sv
src/eye_tracker_top.sv
tests/eye_tracker_props.sv
tests/tb_eye_tracker.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the eye tracker testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eye_tracker -f sim.f --Mdir obj_dir -o tb_eye_tracker > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_eye_tracker > sim.log 2>&1
cat sim.log
grep -q -x ">>> PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
